/* Makefile */
# Verilator build and run for the dual-clock FIFO testbench

VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_async_fifo
FILELIST   = compile.f
OBJ_DIR    = obj_dir
SIM        = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_async_fifo.sv */
module tb_async_fifo
  import cdc_fifo_pkg::*;
();

  localparam int RD_PERIOD     = 40;
  localparam int WR_PERIOD     = 28;
  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_CYCLES = 400;
  localparam int SLOW_PERIOD   = (RD_PERIOD > WR_PERIOD) ? RD_PERIOD : WR_PERIOD;
  localparam int PLANNED_OPS   = RESET_CYCLES + 2 * (FIFO_DEPTH + 3) + 2 * (FIFO_DEPTH + 1)
                                 + RANDOM_CYCLES + FIFO_DEPTH;
  localparam int WATCHDOG_TIME = PLANNED_OPS * SLOW_PERIOD * 4;
  localparam logic [31:0] SEED = 32'h6628550f;

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  data_t      wr_data;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  data_t      rd_data;
  wr_status_t wr_status;
  rd_status_t rd_status;

  data_t       exp_q[$];              // reference model contents
  data_t       last_data = '0;        // word rd_data should hold
  logic [31:0] wr_lfsr;
  logic [31:0] rd_lfsr;
  int          data_errors = 0;
  int          flag_errors = 0;
  int          wr_safety_errors = 0;
  int          rd_safety_errors = 0;

  async_fifo u_dut (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .wr_status (wr_status),
    .rd_status (rd_status)
  );

  always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  function automatic data_t pop_expected();
    if (exp_q.size() == 0) begin
      return last_data; // nothing stored, data holds
    end
    return exp_q.pop_front();
  endfunction

  function automatic wr_status_t settled_wr(input int fill);
    wr_status_t s;
    s.full  = (fill == FIFO_DEPTH);
    s.afull = (fill >= AFULL_LEVEL);
    return s;
  endfunction

  function automatic rd_status_t settled_rd(input int fill);
    rd_status_t s;
    s.empty  = (fill == 0);
    s.aempty = (fill <= AEMPTY_LEVEL);
    return s;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      data_errors++;
      $display("Error at time %0t: %s rd_data is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_wr_status(input wr_status_t got, input wr_status_t exp,
                                 input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("Error at time %0t: %s wr_status full=%b afull=%b, expected full=%b afull=%b",
               $time, what, got.full, got.afull, exp.full, exp.afull);
    end
  endtask

  task automatic check_rd_status(input rd_status_t got, input rd_status_t exp,
                                 input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("Error at time %0t: %s rd_status empty=%b aempty=%b, expected empty=%b aempty=%b",
               $time, what, got.empty, got.aempty, exp.empty, exp.aempty);
    end
  endtask

  task automatic push_word(input data_t d);
    @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = d;
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic pull_word();
    @(negedge rd_clk);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  // idle long enough for both crossings, then flags must be exact
  task automatic settle_and_check(input string what);
    repeat (4) @(posedge rd_clk);
    @(negedge wr_clk);
    check_wr_status(wr_status, settled_wr(exp_q.size()),
                    $sformatf("%s, fill %0d,", what, exp_q.size()));
    @(negedge rd_clk);
    check_rd_status(rd_status, settled_rd(exp_q.size()),
                    $sformatf("%s, fill %0d,", what, exp_q.size()));
  endtask

  // write side model and overflow guard
  always @(posedge wr_clk) begin
    if (wr_rst_n) begin
      if (!wr_status.full && exp_q.size() == FIFO_DEPTH) begin
        wr_safety_errors++;
        $display("Safety violation at time %0t: full is low although the FIFO holds %0d words",
                 $time, FIFO_DEPTH);
      end
      if (wr_en && !wr_status.full) begin
        exp_q.push_back(wr_data);
      end
    end
  end

  // read side model and data compare
  always @(posedge rd_clk) begin
    if (rd_rst_n) begin
      if (!rd_status.empty && exp_q.size() == 0) begin
        rd_safety_errors++;
        $display("Safety violation at time %0t: empty is low although the FIFO holds no words",
                 $time);
      end
      if (rd_en && !rd_status.empty) begin
        last_data = pop_expected();
      end
      #1;
      check_data(rd_data, last_data, "read port");
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] bits;
    logic [31:0] bits_w;
    logic [31:0] bits_r;
    int          guard;
    int          total;

    wr_clk   = 1'b0;
    rd_clk   = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_lfsr  = SEED;
    rd_lfsr  = SEED;

    repeat (RESET_CYCLES) @(posedge rd_clk);
    @(negedge rd_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    check_wr_status(wr_status, wr_status_t'(2'b00), "after reset");
    check_rd_status(rd_status, rd_status_t'(2'b11), "after reset");
    pull_word(); // read while empty, rd_data stays zero
    settle_and_check("reset");

    // fill one word at a time, flags checked at every level
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      take_bits(wr_lfsr, DATA_WIDTH, bits);
      push_word(bits[DATA_WIDTH-1:0]);
      settle_and_check("fill");
    end
    repeat (3) push_word(8'hee); // dropped while full
    settle_and_check("overflow");

    // drain in order, flags at every level on the way down
    guard = 0;
    while (exp_q.size() > 0 && guard < FIFO_DEPTH + 3) begin
      pull_word();
      settle_and_check("drain");
      guard++;
    end
    repeat (3) pull_word();
    settle_and_check("underflow");

    // random traffic on both clocks
    fork
      begin
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
          @(negedge wr_clk);
          take_bits(wr_lfsr, DATA_WIDTH + 1, bits_w);
          wr_en   = bits_w[DATA_WIDTH];
          wr_data = bits_w[DATA_WIDTH-1:0];
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
      end
      begin
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
          @(negedge rd_clk);
          take_bits(rd_lfsr, 2, bits_r);
          rd_en = |bits_r[1:0]; // about three reads in four
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
      end
    join
    settle_and_check("after random traffic");

    guard = 0;
    while (exp_q.size() > 0 && guard < FIFO_DEPTH + 1) begin
      pull_word();
      guard++;
    end
    settle_and_check("final drain");

    total = data_errors + flag_errors + wr_safety_errors + rd_safety_errors;
    $display("summary: %0d data errors, %0d flag errors, %0d overflow and %0d underflow violations",
             data_errors, flag_errors, wr_safety_errors, rd_safety_errors);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/cdc_fifo_pkg.sv
verilog/fifo_mem.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/async_fifo.sv
bench/tb_async_fifo.sv

/* verilog/async_fifo.sv */
module async_fifo
  import cdc_fifo_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  data_t      wr_data,
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  output data_t      rd_data,
  output wr_status_t wr_status,
  output rd_status_t rd_status
);

  ptr_t  wr_gray;     // wr_clk domain, crosses to read side
  ptr_t  rd_gray;     // rd_clk domain, crosses to write side
  logic  mem_wr_en;
  addr_t mem_wr_addr;
  logic  mem_rd_en;
  addr_t mem_rd_addr;

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_gray     (rd_gray),
    .wr_gray     (wr_gray),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .wr_status   (wr_status)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_gray     (wr_gray),
    .rd_gray     (rd_gray),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .rd_status   (rd_status)
  );

  // data goes straight from the port into storage
  fifo_mem u_mem (
    .wr_clk      (wr_clk),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .wr_data     (wr_data),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .rd_data     (rd_data)
  );

endmodule

/* verilog/cdc_fifo_pkg.sv */
package cdc_fifo_pkg;

  localparam int DATA_WIDTH   = 8;
  localparam int ADDR_WIDTH   = 4;
  localparam int FIFO_DEPTH   = 1 << ADDR_WIDTH;
  localparam int AFULL_LEVEL  = 15; // afull at or above this fill
  localparam int AEMPTY_LEVEL = 1;  // aempty at or below this fill

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [ADDR_WIDTH:0]   ptr_t;  // msb is the wrap bit

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic ptr_t bin_to_gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray_to_bin(ptr_t gray);
    ptr_t bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // running xor from the top
    end
    return bin;
  endfunction

endpackage

/* verilog/fifo_mem.sv */
module fifo_mem
  import cdc_fifo_pkg::*;
(
  input  logic  wr_clk,
  input  logic  mem_wr_en,
  input  addr_t mem_wr_addr,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  mem_rd_en,
  input  addr_t mem_rd_addr,
  output data_t rd_data
);

  data_t mem [FIFO_DEPTH];

  // write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr] <= wr_data;
    end
  end

  // registered read port, holds the last word between reads
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (mem_rd_en) begin
      rd_data <= mem[mem_rd_addr];
    end
  end

endmodule

/* verilog/fifo_rd_ctrl.sv */
module fifo_rd_ctrl
  import cdc_fifo_pkg::*;
(
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  ptr_t       wr_gray,
  output ptr_t       rd_gray,
  output logic       mem_rd_en,
  output addr_t      mem_rd_addr,
  output rd_status_t rd_status
);

  ptr_t       rd_bin;
  ptr_t       rd_bin_nxt;
  ptr_t       rd_gray_nxt;
  ptr_t       wr_gray_meta;
  ptr_t       wr_gray_sync;
  ptr_t       wr_bin_sync;
  ptr_t       rd_fill_nxt;
  rd_status_t status_nxt;

  assign mem_rd_en   = rd_en && !rd_status.empty; // accepted read
  assign mem_rd_addr = rd_bin[ADDR_WIDTH-1:0];

  assign rd_bin_nxt  = rd_bin + ptr_t'(mem_rd_en);
  assign rd_gray_nxt = bin_to_gray(rd_bin_nxt);

  assign wr_bin_sync = gray_to_bin(wr_gray_sync);
  assign rd_fill_nxt = wr_bin_sync - rd_bin_nxt;

  always_comb begin
    status_nxt.empty  = (rd_gray_nxt == wr_gray_sync);
    status_nxt.aempty = (rd_fill_nxt <= ptr_t'(AEMPTY_LEVEL));
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // two flop synchronizer for the write pointer
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1; // nothing stored after reset
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status <= status_nxt;
    end
  end

  a_empty_has_aempty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |-> rd_status.aempty
  );

  // the write side samples this pointer asynchronously
  a_rd_gray_one_bit : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  );

  a_no_read_when_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |=> $stable(rd_bin)
  );

endmodule

/* verilog/fifo_wr_ctrl.sv */
module fifo_wr_ctrl
  import cdc_fifo_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  ptr_t       rd_gray,
  output ptr_t       wr_gray,
  output logic       mem_wr_en,
  output addr_t      mem_wr_addr,
  output wr_status_t wr_status
);

  ptr_t       wr_bin;
  ptr_t       wr_bin_nxt;
  ptr_t       wr_gray_nxt;
  ptr_t       rd_gray_meta;
  ptr_t       rd_gray_sync;
  ptr_t       rd_bin_sync;
  ptr_t       wr_fill_nxt;
  ptr_t       rd_gray_full;
  wr_status_t status_nxt;

  assign mem_wr_en   = wr_en && !wr_status.full; // accepted write
  assign mem_wr_addr = wr_bin[ADDR_WIDTH-1:0];

  assign wr_bin_nxt  = wr_bin + ptr_t'(mem_wr_en);
  assign wr_gray_nxt = bin_to_gray(wr_bin_nxt);

  assign rd_bin_sync = gray_to_bin(rd_gray_sync);
  assign wr_fill_nxt = wr_bin_nxt - rd_bin_sync; // mod 2*depth

  // read pointer one lap behind, seen in gray
  assign rd_gray_full = {~rd_gray_sync[ADDR_WIDTH -: 2], rd_gray_sync[ADDR_WIDTH-2:0]};

  always_comb begin
    status_nxt.full  = (wr_gray_nxt == rd_gray_full);
    status_nxt.afull = (wr_fill_nxt >= ptr_t'(AFULL_LEVEL));
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt; // registered, glitch free
    end
  end

  // two flop synchronizer for the read pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status <= status_nxt;
    end
  end

  a_full_has_afull : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |-> wr_status.afull
  );

  // the read side samples this pointer asynchronously
  a_wr_gray_one_bit : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  );

  a_no_write_when_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |=> $stable(wr_bin)
  );

endmodule
